/* bench/rv_axi_slave_model.sv */
`timescale 1ns/1ns

module rv_axi_slave_model #(
    parameter int data_width = 64,
    parameter int seed = 95
) (
    input  logic                    clk,
    input  logic                    reset,
    input  logic [31:0]             awaddr,
    input  logic                    awvalid,
    output logic                    awready,
    input  logic [data_width-1:0]   wdata,
    input  logic [data_width/8-1:0] wstrb,
    input  logic                    wvalid,
    output logic                    wready,
    output logic [1:0]              bresp,
    output logic                    bvalid,
    input  logic                    bready,
    input  logic [31:0]             araddr,
    input  logic                    arvalid,
    output logic                    arready,
    output logic [data_width-1:0]   rdata,
    output logic [1:0]              rresp,
    output logic                    rvalid,
    input  logic                    rready,
    // key register contents
    input  logic [data_width-1:0]   key_value,
    // last write seen at the uart address
    output logic [data_width-1:0]   uart_data,
    output logic [data_width/8-1:0] uart_strb
);

    integer seed_state = seed;

    // remaining wait per channel, ready or valid comes at zero
    logic [1:0] ar_wait;
    logic [1:0] aw_wait;
    logic [1:0] w_wait;
    logic [1:0] r_wait;
    logic [1:0] b_wait;

    logic r_pend;
    logic aw_seen;
    logic w_seen;
    logic [31:0] rd_addr;
    logic [31:0] wr_addr;
    logic [data_width-1:0] w_buf;
    logic [data_width/8-1:0] strb_buf;

    function automatic logic [1:0] pick_delay();
        logic [31:0] r;
        r = $random(seed_state);
        return r[1:0];
    endfunction

    // never errors
    assign bresp = rv_pkg::resp_okay;
    assign rresp = rv_pkg::resp_okay;

    assign arready = (ar_wait == 2'd0);
    assign awready = (aw_wait == 2'd0);
    assign wready  = (w_wait == 2'd0);

    // only the key register reads back non zero
    assign rdata = (rd_addr == rv_pkg::key_addr) ? key_value : '0;

    always @(posedge clk or negedge reset) begin
        if (!reset) begin
            ar_wait   <= 2'd0;
            aw_wait   <= 2'd0;
            w_wait    <= 2'd0;
            r_wait    <= 2'd0;
            b_wait    <= 2'd0;
            r_pend    <= 1'b0;
            aw_seen   <= 1'b0;
            w_seen    <= 1'b0;
            rvalid    <= 1'b0;
            bvalid    <= 1'b0;
            rd_addr   <= '0;
            wr_addr   <= '0;
            uart_data <= '0;
            uart_strb <= '0;
        end else begin
            // ready counts down only while the master waits
            if (arvalid && arready) begin
                ar_wait <= pick_delay();
                rd_addr <= araddr;
                r_pend  <= 1'b1;
            end else if (arvalid) begin
                ar_wait <= ar_wait - 2'd1;
            end
            if (awvalid && awready) begin
                aw_wait <= pick_delay();
                wr_addr <= awaddr;
                aw_seen <= 1'b1;
            end else if (awvalid) begin
                aw_wait <= aw_wait - 2'd1;
            end
            if (wvalid && wready) begin
                w_wait   <= pick_delay();
                w_buf    <= wdata;
                strb_buf <= wstrb;
                w_seen   <= 1'b1;
            end else if (wvalid) begin
                w_wait <= w_wait - 2'd1;
            end
            // read data after its own wait
            if (rvalid && rready) begin
                rvalid <= 1'b0;
                r_pend <= 1'b0;
                r_wait <= pick_delay();
            end else if (r_pend && !rvalid) begin
                if (r_wait == 2'd0) begin
                    rvalid <= 1'b1;
                end else begin
                    r_wait <= r_wait - 2'd1;
                end
            end
            // response once address and data are both in
            if (bvalid && bready) begin
                bvalid  <= 1'b0;
                aw_seen <= 1'b0;
                w_seen  <= 1'b0;
                b_wait  <= pick_delay();
            end else if (aw_seen && w_seen && !bvalid) begin
                if (b_wait == 2'd0) begin
                    bvalid <= 1'b1;
                    if (wr_addr == rv_pkg::uart_addr) begin
                        uart_data <= w_buf;
                        uart_strb <= strb_buf;
                    end
                end else begin
                    b_wait <= b_wait - 2'd1;
                end
            end
        end
    end

endmodule

/* bench/rv_core_tb.sv */
`timescale 1ns/1ns

module rv_core_tb;

    localparam int period = 8;
    localparam int seed = 95;
    localparam int prog_len = 28;
    localparam int num_irqs = 3;
    localparam int timeout_limit = prog_len + 40 * num_irqs + 200;

    logic        clk;
    logic        reset;
    logic [31:0] instruction;
    logic [31:0] pc;
    logic        heartbeat;
    logic        key_irq;
    logic        irq_done;
    logic [4:0]  dbg_addr;
    logic [63:0] dbg_data;

    // axi4-lite between DUT and slave
    logic [31:0] awaddr;
    logic [31:0] araddr;
    logic [63:0] wdata;
    logic [63:0] rdata;
    logic [7:0]  wstrb;
    logic [1:0]  bresp;
    logic [1:0]  rresp;
    logic        awvalid;
    logic        awready;
    logic        wvalid;
    logic        wready;
    logic        bvalid;
    logic        bready;
    logic        arvalid;
    logic        arready;
    logic        rvalid;
    logic        rready;

    logic [63:0] key_value;
    logic [63:0] uart_data;
    logic [7:0]  uart_strb;

    logic [31:0] prog [prog_len];
    logic [63:0] ref_regs [32];
    int reads = 0;
    int writes = 0;
    int dones = 0;
    int cycles = 0;

    rv_core_top #(
        .data_width (64),
        .num_regs   (32)
    ) rv_core_top_i (.*);

    rv_axi_slave_model #(
        .data_width (64),
        .seed       (seed)
    ) slave_i (.*);

    initial clk = 1'b0;
    always #(period / 2) clk = ~clk;

    task automatic abort_run(input string line);
        $display("%s", line);
        $display("RESULT: FAIL");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string msg);
        abort_run($sformatf("MISMATCH at %0t: %s", $time, msg));
    endtask

    function automatic logic [31:0] lui_word(input logic [4:0] rd, input logic [19:0] imm);
        return {imm, rd, rv_pkg::op_lui};
    endfunction

    function automatic logic [31:0] addi_word(input logic [4:0] rd, input logic [4:0] rs1,
                                              input logic [11:0] imm);
        return {imm, rs1, 3'b000, rd, rv_pkg::op_addi};
    endfunction

    // past the program only x0 writes
    function automatic logic [31:0] fetch_word(input logic [31:0] addr);
        if (addr[31:2] < prog_len) begin
            return prog[addr[31:2]];
        end
        return addi_word(5'd0, 5'd0, 12'h000);
    endfunction

    // reference decode straight from the instruction bits
    task automatic model_step(input logic [31:0] w);
        logic [63:0] result;
        logic        has_result;
        result = '0;
        has_result = 1'b1;
        if (w[6:0] == rv_pkg::op_lui) begin
            result = {{32{w[31]}}, w[31:12], 12'h000};
        end else if (w[6:0] == rv_pkg::op_addi && w[14:12] == 3'b000) begin
            result = ref_regs[w[19:15]] + {{52{w[31]}}, w[31:20]};
        end else begin
            has_result = 1'b0;
        end
        if (has_result && w[11:7] != 5'd0) begin
            ref_regs[w[11:7]] = result;
        end
    endtask

    task automatic sweep_registers();
        for (int i = 0; i < 32; i++) begin
            @(posedge clk);
            #1;
            dbg_addr = 5'(i);
            #2;
            assert (dbg_data === ref_regs[i])
            else report_mismatch($sformatf("x%0d is %h, expected %h", i, dbg_data, ref_regs[i]));
        end
    endtask

    task automatic run_irq(input logic [63:0] key, input int count);
        @(posedge clk);
        #1;
        key_value = key;
        key_irq = 1'b1;
        // irq_done is settled by the falling edge
        do begin
            @(negedge clk);
        end while (!irq_done);
        @(posedge clk);
        #1;
        key_irq = 1'b0;
        assert (uart_data === key && uart_strb === 8'hff)
        else report_mismatch($sformatf("uart got %h strb %h, key %h", uart_data, uart_strb, key));
        assert (reads == count && writes == count && dones == count)
        else report_mismatch($sformatf("irq %0d saw %0d reads %0d writes %0d done pulses",
                                       count, reads, writes, dones));
    endtask

    // instruction for the current pc, just after the edge
    always @(posedge clk) begin
        #1;
        instruction = fetch_word(pc);
    end

    // the word seen while irq_done is high is squashed
    always @(negedge clk) begin
        if (reset && !irq_done) begin
            model_step(instruction);
        end
        if (arvalid && arready) begin
            reads++;
        end
        if (awvalid && awready) begin
            writes++;
        end
        if (irq_done) begin
            dones++;
        end
    end

    always @(negedge clk) begin
        cycles++;
        if (cycles > timeout_limit) begin
            abort_run($sformatf("timeout: run did not finish within %0d cycles", timeout_limit));
        end
    end

    // first edge out of reset sees reset values
    assert property (@(posedge clk) $rose(reset) |-> pc == 32'd0 && !heartbeat && !irq_done &&
        !awvalid && !wvalid && !arvalid && !bready && !rready)
    else report_mismatch("outputs not at reset values after reset release");

    assert property (@(posedge clk) disable iff (!reset)
        1'b1 |=> heartbeat != $past(heartbeat))
    else report_mismatch("heartbeat did not toggle");

    assert property (@(posedge clk) disable iff (!reset)
        !irq_done |=> pc == $past(pc) + 32'd4)
    else report_mismatch("pc did not advance by 4");

    assert property (@(posedge clk) disable iff (!reset)
        irq_done |=> pc == rv_pkg::reset_pc && !irq_done)
    else report_mismatch("pc not restarted or irq_done longer than one cycle");

    // master holds valid and payload under back-pressure
    assert property (@(posedge clk) disable iff (!reset)
        arvalid && !arready |=> arvalid && $stable(araddr))
    else report_mismatch("read address dropped before handshake");

    assert property (@(posedge clk) disable iff (!reset)
        awvalid && !awready |=> awvalid && $stable(awaddr))
    else report_mismatch("write address dropped before handshake");

    assert property (@(posedge clk) disable iff (!reset)
        wvalid && !wready |=> wvalid && $stable(wdata) && $stable(wstrb))
    else report_mismatch("write data dropped before handshake");

    assert property (@(posedge clk) disable iff (!reset)
        rready && !rvalid |=> rready)
    else report_mismatch("rready dropped while waiting");

    assert property (@(posedge clk) disable iff (!reset)
        bready && !bvalid |=> bready)
    else report_mismatch("bready dropped while waiting");

    assert property (@(posedge clk) disable iff (!reset)
        arvalid |-> araddr == rv_pkg::key_addr)
    else report_mismatch("read not at key address");

    assert property (@(posedge clk) disable iff (!reset)
        awvalid |-> awaddr == rv_pkg::uart_addr)
    else report_mismatch("write not at uart address");

    assert property (@(posedge clk) disable iff (!reset)
        wvalid |-> wdata == key_value && wstrb == 8'hff)
    else report_mismatch("write data or strobe wrong");

    initial begin
        reset = 1'b0;
        key_irq = 1'b0;
        dbg_addr = 5'd0;
        key_value = '0;
        for (int i = 0; i < 32; i++) begin
            ref_regs[i] = '0;
        end
        // negative immediates, x0 writes, back to back dependences
        prog[0]  = lui_word(5'd1, 20'h12345);
        prog[1]  = addi_word(5'd1, 5'd1, 12'h678);
        prog[2]  = addi_word(5'd2, 5'd0, 12'hfff);
        prog[3]  = lui_word(5'd3, 20'hfffff);
        prog[4]  = addi_word(5'd3, 5'd3, 12'h800);
        prog[5]  = addi_word(5'd0, 5'd1, 12'h005);
        prog[6]  = lui_word(5'd0, 20'habcde);
        prog[7]  = addi_word(5'd4, 5'd2, 12'hffb);
        prog[8]  = addi_word(5'd5, 5'd4, 12'h064);
        prog[9]  = lui_word(5'd31, 20'h80000);
        prog[10] = addi_word(5'd31, 5'd31, 12'h001);
        // counter run, long enough that the squashed slot is still a register write
        for (int i = 11; i < prog_len; i++) begin
            prog[i] = addi_word(5'd7, 5'd7, 12'h001);
        end
        instruction = fetch_word(32'd0);
        repeat (8) @(posedge clk);
        #1;
        reset = 1'b1;
        repeat (prog_len + 4) @(posedge clk);
        sweep_registers();
        run_irq(64'h0123_4567_89ab_cdef, 1);
        repeat (6) @(posedge clk);
        run_irq(64'hfedc_ba98_7654_3210, 2);
        repeat (3) @(posedge clk);
        run_irq(64'h0000_0000_0000_005a, 3);
        repeat (prog_len + 4) @(posedge clk);
        sweep_registers();
        if (reads == num_irqs && writes == num_irqs && dones == num_irqs) begin
            $display("RESULT: PASS");
            $finish;
        end else begin
            report_mismatch("transfer count wrong at end of run");
        end
    end

endmodule

/* design/rv_core_top.sv */
`timescale 1ns/1ns

module rv_core_top #(
    parameter int data_width = rv_pkg::xlen,
    parameter int num_regs = 32
) (
    input  logic                            clk,
    input  logic                            reset,

    // instruction side
    input  logic [31:0]                     instruction,
    output logic [31:0]                     pc,
    output logic                            heartbeat,

    // keyboard interrupt
    input  logic                            key_irq,
    output logic                            irq_done,

    // register file debug read
    input  logic [4:0]                      dbg_addr,
    output logic [data_width-1:0]           dbg_data,

    // axi4-lite write
    output logic [rv_pkg::addr_width-1:0]   awaddr,
    output logic                            awvalid,
    input  logic                            awready,
    output logic [data_width-1:0]           wdata,
    output logic [data_width/8-1:0]         wstrb,
    output logic                            wvalid,
    input  logic                            wready,
    input  logic [1:0]                      bresp,
    input  logic                            bvalid,
    output logic                            bready,

    // axi4-lite read
    output logic [rv_pkg::addr_width-1:0]   araddr,
    output logic                            arvalid,
    input  logic                            arready,
    input  logic [data_width-1:0]           rdata,
    input  logic [1:0]                      rresp,
    input  logic                            rvalid,
    output logic                            rready
);

    // copier to fetch
    logic              redirect;

    // fetch to execute
    rv_pkg::rv_instr_u ir;
    logic              ir_valid;

    // pc, ir and squash
    rv_fetch rv_fetch_i (
        .clk         (clk),
        .reset       (reset),
        .instruction (instruction),
        .redirect    (redirect),
        .pc          (pc),
        .ir          (ir),
        .ir_valid    (ir_valid),
        .heartbeat   (heartbeat)
    );

    // lui, addi and register file
    rv_execute #(
        .data_width (data_width),
        .num_regs   (num_regs)
    ) rv_execute_i (
        .clk      (clk),
        .reset    (reset),
        .ir       (ir),
        .ir_valid (ir_valid),
        .dbg_addr (dbg_addr),
        .dbg_data (dbg_data)
    );

    // key to uart copy over axi
    rv_irq_copy #(
        .data_width (data_width)
    ) rv_irq_copy_i (
        .clk      (clk),
        .reset    (reset),
        .key_irq  (key_irq),
        .awaddr   (awaddr),
        .awvalid  (awvalid),
        .awready  (awready),
        .wdata    (wdata),
        .wstrb    (wstrb),
        .wvalid   (wvalid),
        .wready   (wready),
        .bresp    (bresp),
        .bvalid   (bvalid),
        .bready   (bready),
        .araddr   (araddr),
        .arvalid  (arvalid),
        .arready  (arready),
        .rdata    (rdata),
        .rresp    (rresp),
        .rvalid   (rvalid),
        .rready   (rready),
        .irq_done (irq_done),
        .redirect (redirect)
    );

endmodule

/* design/rv_execute.sv */
`timescale 1ns/1ns

module rv_execute #(
    parameter int data_width = rv_pkg::xlen,
    parameter int num_regs = 32
) (
    input  logic                  clk,
    input  logic                  reset,
    input  rv_pkg::rv_instr_u     ir,
    input  logic                  ir_valid,
    // debug read port, combinational
    input  logic [4:0]            dbg_addr,
    output logic [data_width-1:0] dbg_data
);

    // integer register file
    logic [data_width-1:0] regs [num_regs];

    // decode
    logic is_lui;
    logic is_addi;

    // immediates, sign extended to the register width
    logic [data_width-1:0] imm_u;
    logic [data_width-1:0] imm_i;

    // source operand for addi
    logic [data_width-1:0] rs1_val;

    // writeback
    logic                  wr_en;
    logic [4:0]            wr_rd;
    logic [data_width-1:0] wr_data;

    // opcode match, lui through the u view and addi through the i view
    always_comb begin
        is_lui  = (ir.utype.opcode == rv_pkg::op_lui);
        is_addi = (ir.itype.opcode == rv_pkg::op_addi) &&
                  (ir.itype.funct3 == rv_pkg::f3_addi);
    end

    // lui: imm20 into bits 31:12, upper bits copy bit 31
    assign imm_u = {{(data_width - 32){ir.utype.imm20[19]}}, ir.utype.imm20, 12'b0};

    // addi: 12 bit immediate sign extended
    assign imm_i = {{(data_width - 12){ir.itype.imm12[11]}}, ir.itype.imm12};

    // rs1 read, x0 is hard zero
    always_comb begin
        if (ir.itype.rs1 == 5'd0) begin
            rs1_val = '0;
        end else begin
            rs1_val = regs[ir.itype.rs1];
        end
    end

    // result and destination
    // rd sits at the same bits in both views
    always_comb begin
        wr_rd = ir.utype.rd;
        if (is_lui) begin
            wr_data = imm_u;
        end else begin
            wr_data = rs1_val + imm_i;
        end
        // bubbles, unknown opcodes and x0 writes drop out here
        wr_en = ir_valid && (is_lui || is_addi) && (wr_rd != 5'd0);
    end

    // register file write, result lands one edge after ir
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            for (int i = 0; i < num_regs; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wr_rd] <= wr_data;
        end
    end

    // debug port
    always_comb begin
        if (dbg_addr == 5'd0) begin
            dbg_data = '0;
        end else begin
            dbg_data = regs[dbg_addr];
        end
    end

endmodule

/* design/rv_fetch.sv */
`timescale 1ns/1ns

module rv_fetch (
    input  logic              clk,
    input  logic              reset,
    // instruction word for the current pc
    input  logic [31:0]       instruction,
    // one cycle pulse from the interrupt copier
    input  logic              redirect,
    output logic [31:0]       pc,
    output rv_pkg::rv_instr_u ir,
    output logic              ir_valid,
    output logic              heartbeat
);

    // squash request for the ir load on the edge after redirect
    logic squash;

    // the word fetched while redirect is high is on the old path
    assign squash = redirect;

    // pc, valid flag and heartbeat
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            pc        <= rv_pkg::reset_pc;
            ir_valid  <= 1'b0;
            heartbeat <= 1'b0;
        end else begin
            // toggles every cycle
            heartbeat <= ~heartbeat;

            // squashed slot reaches execute as a bubble
            ir_valid <= ~squash;

            // restart at the vector, else next word
            if (redirect) begin
                pc <= rv_pkg::reset_pc;
            end else begin
                pc <= pc + 32'd4;
            end
        end
    end

    // instruction register
    // loaded every edge, ir_valid tells execute whether to use it
    always_ff @(posedge clk) begin
        ir <= instruction;
    end

endmodule

/* design/rv_irq_copy.sv */
`timescale 1ns/1ns

module rv_irq_copy #(
    parameter int data_width = rv_pkg::xlen
) (
    input  logic                            clk,
    input  logic                            reset,
    // level request, held until irq_done
    input  logic                            key_irq,

    // write address channel
    output logic [rv_pkg::addr_width-1:0]   awaddr,
    output logic                            awvalid,
    input  logic                            awready,

    // write data channel
    output logic [data_width-1:0]           wdata,
    output logic [data_width/8-1:0]         wstrb,
    output logic                            wvalid,
    input  logic                            wready,

    // write response, any code ends the write
    input  logic [1:0]                      bresp,
    input  logic                            bvalid,
    output logic                            bready,

    // read address channel
    output logic [rv_pkg::addr_width-1:0]   araddr,
    output logic                            arvalid,
    input  logic                            arready,

    // read data, any code still forwards rdata
    input  logic [data_width-1:0]           rdata,
    input  logic [1:0]                      rresp,
    input  logic                            rvalid,
    output logic                            rready,

    // completion and pc restart, same cycle
    output logic                            irq_done,
    output logic                            redirect
);

    // fsm encoding
    localparam logic [2:0] st_idle     = 3'd0;
    localparam logic [2:0] st_rd_addr  = 3'd1;
    localparam logic [2:0] st_rd_data  = 3'd2;
    localparam logic [2:0] st_wr       = 3'd3;
    localparam logic [2:0] st_wr_resp  = 3'd4;
    localparam logic [2:0] st_done     = 3'd5;
    localparam logic [2:0] st_wait_rel = 3'd6;

    logic [2:0] state;

    // aw and w still waiting for their own handshake
    logic aw_pend;
    logic w_pend;

    // channel finished by now or on this edge
    logic aw_ok;
    logic w_ok;

    // fixed addresses and full strobe, stable for the whole transfer
    assign araddr = rv_pkg::key_addr;
    assign awaddr = rv_pkg::uart_addr;
    assign wstrb  = {(data_width/8){1'b1}};

    // valids and readies decoded from state, never from ready
    assign arvalid = (state == st_rd_addr);
    assign rready  = (state == st_rd_data);
    assign awvalid = (state == st_wr) && aw_pend;
    assign wvalid  = (state == st_wr) && w_pend;
    assign bready  = (state == st_wr_resp);

    // one cycle pulse
    assign irq_done = (state == st_done);
    assign redirect = (state == st_done);

    assign aw_ok = !aw_pend || awready;
    assign w_ok  = !w_pend || wready;

    // control
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            state   <= st_idle;
            aw_pend <= 1'b0;
            w_pend  <= 1'b0;
        end else begin
            case (state)
                st_idle: begin
                    if (key_irq) begin
                        state <= st_rd_addr;
                    end
                end
                st_rd_addr: begin
                    if (arready) begin
                        state <= st_rd_data;
                    end
                end
                st_rd_data: begin
                    // aw and w raised together
                    if (rvalid) begin
                        state   <= st_wr;
                        aw_pend <= 1'b1;
                        w_pend  <= 1'b1;
                    end
                end
                st_wr: begin
                    // each channel drops on its own handshake
                    if (awready) begin
                        aw_pend <= 1'b0;
                    end
                    if (wready) begin
                        w_pend <= 1'b0;
                    end
                    if (aw_ok && w_ok) begin
                        state <= st_wr_resp;
                    end
                end
                st_wr_resp: begin
                    if (bvalid) begin
                        state <= st_done;
                    end
                end
                st_done: begin
                    state <= st_wait_rel;
                end
                st_wait_rel: begin
                    // no restart until the request is released
                    if (!key_irq) begin
                        state <= st_idle;
                    end
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    // key value captured on the r handshake
    always_ff @(posedge clk) begin
        if (rvalid && rready) begin
            wdata <= rdata;
        end
    end

endmodule

/* design/rv_pkg.sv */
package rv_pkg;

    // datapath and bus widths
    localparam int xlen = 64;
    localparam int addr_width = 32;

    // major opcodes, bits 6:0 of the instruction
    localparam logic [6:0] op_lui = 7'b0110111;
    localparam logic [6:0] op_addi = 7'b0010011;

    // addi is op-imm with funct3 zero
    localparam logic [2:0] f3_addi = 3'b000;

    // memory mapped peripherals
    localparam logic [31:0] uart_addr = 32'h8000_0000;
    localparam logic [31:0] key_addr = 32'h8000_0010;

    // axi response code for a good transfer
    localparam logic [1:0] resp_okay = 2'b00;

    // start address after reset and after the interrupt redirect
    localparam logic [31:0] reset_pc = 32'h0000_0000;

    // u-type layout, lui
    typedef struct packed {
        logic [19:0] imm20;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } rv_utype_s;

    // i-type layout, addi
    typedef struct packed {
        logic [11:0] imm12;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } rv_itype_s;

    // one instruction word, two decodings
    // opcode and rd sit at the same bits in both views
    typedef union packed {
        rv_utype_s utype;
        rv_itype_s itype;
    } rv_instr_u;

endpackage

/* flist.f */
design/rv_pkg.sv
design/rv_fetch.sv
design/rv_execute.sv
design/rv_irq_copy.sv
design/rv_core_top.sv
bench/rv_axi_slave_model.sv
bench/rv_core_tb.sv
